/* eccEncoder.sv */
`timescale 1ns/1ps

// Write side of the memory
// A write request is encoded into a Hsiao codeword and registered for the RAM
// so the RAM sees the strobe one cycle after wrEn
module eccEncoder (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            wrEn,
  input  logic [eccMemPkg::AddrWidth-1:0] wrAddr,
  input  logic [eccMemPkg::DataWidth-1:0] wrData,
  input  logic [eccMemPkg::CodeWidth-1:0] wrFlipMask,
  output logic                            memWrEn,
  output logic [eccMemPkg::AddrWidth-1:0] memWrAddr,
  output logic [eccMemPkg::CodeWidth-1:0] memWrCode
);

  import eccMemPkg::*;

  // Check bits computed from the data alone
  logic [ParityWidth-1:0] checkBits;

  // Encoded word before fault injection
  logic [CodeWidth-1:0] cleanCode;

  // Encoded word with the injection mask applied
  logic [CodeWidth-1:0] faultyCode;

  // The check field is zero here, so the parity of each row only sees data bits
  assign checkBits = calcSyndrome({{ParityWidth{1'b0}}, wrData});

  // Check bits sit above the data in the codeword
  assign cleanCode = {checkBits, wrData};

  // Every set bit of the mask flips the matching codeword bit
  // This lets self-test corrupt data bits and check bits alike
  assign faultyCode = cleanCode ^ wrFlipMask;

  // Only the strobe needs a defined value out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      memWrEn <= 1'b0;
    end else begin
      memWrEn <= wrEn;
    end
  end

  // Address and codeword are held until the next write request
  always_ff @(posedge clk) begin
    if (wrEn) begin
      memWrAddr <= wrAddr;
      memWrCode <= faultyCode;
    end
  end

endmodule

/* eccErrorLog.sv */
`timescale 1ns/1ps

// Error statistics for the memory
// Counts corrected and uncorrectable reads and keeps the address of the last
// uncorrectable one, all updated on the cycle after rdValid
module eccErrorLog (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             rdValid,
  input  logic [eccMemPkg::AddrWidth-1:0]  rdAddrOut,
  input  eccMemPkg::eccStatusE             rdStatus,
  output logic [eccMemPkg::CountWidth-1:0] corrCount,
  output logic [eccMemPkg::CountWidth-1:0] uncorrCount,
  output logic [eccMemPkg::AddrWidth-1:0]  lastErrAddr
);

  import eccMemPkg::*;

  // One strobe per kind of event
  logic corrHit;
  logic uncorrHit;

  // Status is only meaningful while rdValid is high
  assign corrHit   = rdValid && (rdStatus == EccCorrected);
  assign uncorrHit = rdValid && (rdStatus == EccUncorrectable);

  // Counters stop at all ones instead of wrapping back to zero
  always_ff @(posedge clk) begin
    if (rst) begin
      corrCount   <= '0;
      uncorrCount <= '0;
    end else begin
      if (corrHit && (corrCount != '1)) begin
        corrCount <= corrCount + 1'b1;
      end
      if (uncorrHit && (uncorrCount != '1)) begin
        uncorrCount <= uncorrCount + 1'b1;
      end
    end
  end

  // Each new uncorrectable read overwrites the address
  // Corrected reads leave it alone because their data came back intact
  always_ff @(posedge clk) begin
    if (rst) begin
      lastErrAddr <= '0;
    end else if (uncorrHit) begin
      lastErrAddr <= rdAddrOut;
    end
  end

endmodule

/* eccMem.f */
eccMemPkg.sv
eccEncoder.sv
eccStorage.sv
hsiaoCorrector.sv
eccErrorLog.sv
eccMemTop.sv
tbEccMem.sv

/* eccMemPkg.sv */
// Shared widths, the Hsiao check matrix, the read status type and the syndrome function
// for the ECC-protected memory
package eccMemPkg;

  // Data bits carried by each word
  localparam int unsigned DataWidth = 32;

  // Hsiao SEC-DED needs clog2(DataWidth) + 2 check bits
  localparam int unsigned ParityWidth = 7;

  // Codeword holds the data in the low bits and the check bits above it
  localparam int unsigned CodeWidth = DataWidth + ParityWidth;

  // Address bits and number of RAM entries
  localparam int unsigned AddrWidth = 4;
  localparam int unsigned Depth = 2 ** AddrWidth;

  // Error counters stick at their maximum value
  localparam int unsigned CountWidth = 8;

  // One row per check bit, listing the codeword bits that this check bit covers
  // Data column j is the j-th weight-3 pattern of 7 bits in ascending order
  // (7, 11, 13, 14, 19, ... 97, 98), so every data column is distinct and of odd weight
  // Check column k has bit k alone set, which puts bit 32+k into row k
  // Every row below was derived from that column list by hand
  localparam logic [CodeWidth-1:0] HsiaoMasks [ParityWidth] = '{
    // Row 0 covers data 0 1 2 4 5 7 10 11 13 16 20 21 23 26 30
    39'h0144B12CB7,
    // Row 1 covers data 0 1 3 4 6 8 10 12 14 17 20 22 24 27 31
    39'h028952555B,
    // Row 2 covers data 0 2 3 5 6 9 11 12 15 18 21 22 25 28
    39'h0412649A6D,
    // Row 3 covers data 1 2 3 7 8 9 13 14 15 19 23 24 25 29
    39'h082388E38E,
    // Row 4 covers data 4 to 9, 16 to 19 and 26 to 29
    39'h103C0F03F0,
    // Row 5 covers data 10 to 19 plus 30 and 31
    39'h20C00FFC00,
    // Row 6 covers data 20 to 31
    39'h40FFF00000
  };

  // Outcome of one read
  // EccOk means the syndrome was zero
  // EccCorrected means a single flipped bit was repaired
  // EccUncorrectable means an even number of bits flipped and the data is not trusted
  typedef enum logic [1:0] {
    EccOk            = 2'd0,
    EccCorrected     = 2'd1,
    EccUncorrectable = 2'd2
  } eccStatusE;

  // Parity of the codeword under each row of the matrix
  // With the check field held at zero this yields the check bits of the data
  // On a stored codeword it yields the syndrome, which is zero for a clean word
  function automatic logic [ParityWidth-1:0] calcSyndrome(
    input logic [CodeWidth-1:0] code
  );
    logic [ParityWidth-1:0] syndrome;
    for (int k = 0; k < ParityWidth; k++) begin
      syndrome[k] = ^(code & HsiaoMasks[k]);
    end
    return syndrome;
  endfunction

endpackage

/* eccMemTop.sv */
`timescale 1ns/1ps

// ECC-protected memory of 16 words of 32 bits
// Write path is encoder then RAM
// Read path is RAM then corrector, with the error log watching the corrector output
// Read results arrive two cycles after rdEn and the log updates one cycle later
module eccMemTop (
  input  logic                             clk,
  input  logic                             rst,

  // Write request, a single-cycle strobe with its values
  input  logic                             wrEn,
  input  logic [eccMemPkg::AddrWidth-1:0]  wrAddr,
  input  logic [eccMemPkg::DataWidth-1:0]  wrData,
  input  logic [eccMemPkg::CodeWidth-1:0]  wrFlipMask,

  // Read request, a single-cycle strobe with its address
  input  logic                             rdEn,
  input  logic [eccMemPkg::AddrWidth-1:0]  rdAddr,

  // Read result
  output logic                             rdValid,
  output logic [eccMemPkg::DataWidth-1:0]  rdData,
  output eccMemPkg::eccStatusE             rdStatus,

  // Error log
  output logic [eccMemPkg::CountWidth-1:0] corrCount,
  output logic [eccMemPkg::CountWidth-1:0] uncorrCount,
  output logic [eccMemPkg::AddrWidth-1:0]  lastErrAddr
);

  import eccMemPkg::*;

  // Encoder to RAM
  logic                 memWrEn;
  logic [AddrWidth-1:0] memWrAddr;
  logic [CodeWidth-1:0] memWrCode;

  // RAM to corrector
  logic                 memRdValid;
  logic [AddrWidth-1:0] memRdAddr;
  logic [CodeWidth-1:0] memRdCode;

  // Corrector to error log
  logic [AddrWidth-1:0] rdAddrOut;

  // Encoding and fault injection
  eccEncoder i_eccEncoder (
    .clk        (clk),
    .rst        (rst),
    .wrEn       (wrEn),
    .wrAddr     (wrAddr),
    .wrData     (wrData),
    .wrFlipMask (wrFlipMask),
    .memWrEn    (memWrEn),
    .memWrAddr  (memWrAddr),
    .memWrCode  (memWrCode)
  );

  // Codeword storage
  eccStorage i_eccStorage (
    .clk        (clk),
    .rst        (rst),
    .memWrEn    (memWrEn),
    .memWrAddr  (memWrAddr),
    .memWrCode  (memWrCode),
    .rdEn       (rdEn),
    .rdAddr     (rdAddr),
    .memRdValid (memRdValid),
    .memRdAddr  (memRdAddr),
    .memRdCode  (memRdCode)
  );

  // Syndrome decode and single-bit repair
  hsiaoCorrector i_hsiaoCorrector (
    .clk        (clk),
    .rst        (rst),
    .memRdValid (memRdValid),
    .memRdAddr  (memRdAddr),
    .memRdCode  (memRdCode),
    .rdValid    (rdValid),
    .rdAddrOut  (rdAddrOut),
    .rdData     (rdData),
    .rdStatus   (rdStatus)
  );

  // Error statistics
  eccErrorLog i_eccErrorLog (
    .clk         (clk),
    .rst         (rst),
    .rdValid     (rdValid),
    .rdAddrOut   (rdAddrOut),
    .rdStatus    (rdStatus),
    .corrCount   (corrCount),
    .uncorrCount (uncorrCount),
    .lastErrAddr (lastErrAddr)
  );

endmodule

/* eccStorage.sv */
`timescale 1ns/1ps

// Codeword RAM with one write port and one registered read port
// Read data, read address and the valid flag all appear one cycle after rdEn
module eccStorage (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            memWrEn,
  input  logic [eccMemPkg::AddrWidth-1:0] memWrAddr,
  input  logic [eccMemPkg::CodeWidth-1:0] memWrCode,
  input  logic                            rdEn,
  input  logic [eccMemPkg::AddrWidth-1:0] rdAddr,
  output logic                            memRdValid,
  output logic [eccMemPkg::AddrWidth-1:0] memRdAddr,
  output logic [eccMemPkg::CodeWidth-1:0] memRdCode
);

  import eccMemPkg::*;

  // Storage array holding full codewords including check bits
  logic [CodeWidth-1:0] mem [Depth];

  // Writes land on the edge after memWrEn is seen
  always_ff @(posedge clk) begin
    if (memWrEn) begin
      mem[memWrAddr] <= memWrCode;
    end
  end

  // A read in the same cycle as a write to that address returns the old word
  always_ff @(posedge clk) begin
    if (rdEn) begin
      memRdCode <= mem[rdAddr];
      memRdAddr <= rdAddr;
    end
  end

  // Valid flag marks the cycle in which memRdCode belongs to a read
  always_ff @(posedge clk) begin
    if (rst) begin
      memRdValid <= 1'b0;
    end else begin
      memRdValid <= rdEn;
    end
  end

endmodule

/* hsiaoCorrector.sv */
`timescale 1ns/1ps

// Read side decoder for the Hsiao SEC-DED code
// It computes the syndrome of the stored word, repairs a single flipped bit,
// classifies the read and registers the result one cycle after memRdValid
module hsiaoCorrector (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            memRdValid,
  input  logic [eccMemPkg::AddrWidth-1:0] memRdAddr,
  input  logic [eccMemPkg::CodeWidth-1:0] memRdCode,
  output logic                            rdValid,
  output logic [eccMemPkg::AddrWidth-1:0] rdAddrOut,
  output logic [eccMemPkg::DataWidth-1:0] rdData,
  output eccMemPkg::eccStatusE            rdStatus
);

  import eccMemPkg::*;

  // Syndrome of the word as it came out of the RAM
  logic [ParityWidth-1:0] syndrome;

  // Codeword after the bit named by the syndrome has been flipped back
  logic [CodeWidth-1:0] fixedCode;

  // Classification of the current read
  eccStatusE status;

  // A clean word gives zero because each row is even over a valid codeword
  assign syndrome = calcSyndrome(memRdCode);

  // Each codeword bit has its own column in the matrix
  // A single error makes the syndrome equal to the column of the flipped bit
  for (genvar j = 0; j < CodeWidth; j++) begin : genCorrect
    logic [ParityWidth-1:0] column;

    // Column j is bit j of every row mask
    for (genvar k = 0; k < ParityWidth; k++) begin : genColumn
      assign column[k] = HsiaoMasks[k][j];
    end

    // All columns have odd weight, so an even syndrome never flips anything
    assign fixedCode[j] = memRdCode[j] ^ (syndrome == column);
  end

  // Odd syndrome weight points to one flipped bit
  // Nonzero even weight means two bits flipped and cannot be repaired
  // Three or more flips fall into whichever class the syndrome weight gives
  always_comb begin
    if (syndrome == '0) begin
      status = EccOk;
    end else if (^syndrome) begin
      status = EccCorrected;
    end else begin
      status = EccUncorrectable;
    end
  end

  // Only the data field leaves the module
  // The repaired check bits are dropped since nothing writes them back
  always_ff @(posedge clk) begin
    if (memRdValid) begin
      rdData    <= fixedCode[DataWidth-1:0];
      rdStatus  <= status;
      rdAddrOut <= memRdAddr;
    end
  end

  // rdValid follows memRdValid by one cycle, so reads pipeline one per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      rdValid <= 1'b0;
    end else begin
      rdValid <= memRdValid;
    end
  end

endmodule

/* tbEccMem.sv */
`timescale 1ns/1ps

// Testbench for the ECC-protected memory
// Each table row writes one word through a flip mask, reads it back and compares
// data and status with what the number of flipped codeword bits predicts
module tbEccMem;

  import eccMemPkg::*;

  localparam int ClkPeriod = 100;
  localparam int ResetCycles = 3;
  localparam int unsigned Seed = 59566;

  // Row groups of the table
  localparam int NumClean = 4;
  localparam int NumSingle = CodeWidth;
  localparam int NumDouble = 6;
  localparam int NumRows = NumClean + NumSingle + NumDouble;

  // Words read on consecutive cycles in the pipelining test
  localparam int NumBurst = 4;

  // A read that shows no rdValid after this many cycles counts as lost
  localparam int ValidLimit = 8;

  // Budget for the whole run, well above the five or so cycles one row needs
  localparam int WatchdogCycles = NumRows * 10 + 50;

  logic                  clk;
  logic                  rst;
  logic                  wrEn;
  logic [AddrWidth-1:0]  wrAddr;
  logic [DataWidth-1:0]  wrData;
  logic [CodeWidth-1:0]  wrFlipMask;
  logic                  rdEn;
  logic [AddrWidth-1:0]  rdAddr;
  logic                  rdValid;
  logic [DataWidth-1:0]  rdData;
  eccStatusE             rdStatus;
  logic [CountWidth-1:0] corrCount;
  logic [CountWidth-1:0] uncorrCount;
  logic [AddrWidth-1:0]  lastErrAddr;

  // Stimulus and expected status, one entry per row
  logic [AddrWidth-1:0] rowAddr [NumRows];
  logic [DataWidth-1:0] rowData [NumRows];
  logic [CodeWidth-1:0] rowMask [NumRows];
  eccStatusE            rowStatus [NumRows];

  int errorCount;
  int testCount;
  int testFailCount;

  eccMemTop i_eccMemTop (
    .clk         (clk),
    .rst         (rst),
    .wrEn        (wrEn),
    .wrAddr      (wrAddr),
    .wrData      (wrData),
    .wrFlipMask  (wrFlipMask),
    .rdEn        (rdEn),
    .rdAddr      (rdAddr),
    .rdValid     (rdValid),
    .rdData      (rdData),
    .rdStatus    (rdStatus),
    .corrCount   (corrCount),
    .uncorrCount (uncorrCount),
    .lastErrAddr (lastErrAddr)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Ends a run that stalls somewhere
  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles before all tests finished", WatchdogCycles);
    $display("TB FAILED");
    $finish;
  end

  // Zero flips read back clean, one flip is repaired, two flips cannot be
  function automatic eccStatusE expectedStatus(input logic [CodeWidth-1:0] mask);
    int flips;
    flips = $countones(mask);
    if (flips == 0) begin
      return EccOk;
    end else if (flips == 1) begin
      return EccCorrected;
    end
    return EccUncorrectable;
  endfunction

  // Two-bit masks covering data pairs, data with check bits and check pairs
  function automatic logic [CodeWidth-1:0] pairMask(input int p);
    case (p)
      0:       return 39'h0000000003;  // Bits 0 and 1
      1:       return 39'h0080000020;  // Bits 5 and 31
      2:       return 39'h0800001000;  // Bits 12 and 35
      3:       return 39'h4100000000;  // Bits 32 and 38
      4:       return 39'h0200100000;  // Bits 20 and 33
      default: return 39'h0004000080;  // Bits 7 and 26
    endcase
  endfunction

  function automatic string statusText(input eccStatusE s);
    case (s)
      EccOk:            return "EccOk";
      EccCorrected:     return "EccCorrected";
      EccUncorrectable: return "EccUncorrectable";
      default:          return "unknown";
    endcase
  endfunction

  task automatic checkData(
    input logic [DataWidth-1:0] got,
    input logic [DataWidth-1:0] exp,
    input string                what
  );
    if (got !== exp) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s data expected %h got %h", $time, what, exp, got);
    end
  endtask

  task automatic checkStatus(input eccStatusE got, input eccStatusE exp, input string what);
    if (got !== exp) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s status expected %s got %s",
               $time, what, statusText(exp), statusText(got));
    end
  endtask

  task automatic checkCount(
    input logic [CountWidth-1:0] got,
    input logic [CountWidth-1:0] exp,
    input string                 what
  );
    if (got !== exp) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, what, exp, got);
    end
  endtask

  task automatic checkAddr(
    input logic [AddrWidth-1:0] got,
    input logic [AddrWidth-1:0] exp,
    input string                what
  );
    if (got !== exp) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, what, exp, got);
    end
  endtask

  task automatic checkFlag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s expected %b got %b", $time, what, exp, got);
    end
  endtask

  // Prints the one-line verdict of a test from the errors it added
  task automatic finishTest(input string name, input int errorsBefore);
    testCount++;
    if (errorCount != errorsBefore) begin
      testFailCount++;
      $display("test %0d %s : fail", testCount, name);
    end else begin
      $display("test %0d %s : pass", testCount, name);
    end
  endtask

  // Fills the table, random data drawn after the seed is set
  task automatic buildTable();
    int row;
    logic [CodeWidth-1:0] mask;
    row = 0;
    for (int i = 0; i < NumClean; i++) begin
      rowMask[row] = '0;
      case (i)
        0:       rowData[row] = '0;
        1:       rowData[row] = '1;
        default: rowData[row] = $urandom();
      endcase
      row++;
    end
    // Every codeword position alone, the check bits included
    for (int b = 0; b < NumSingle; b++) begin
      mask = '0;
      mask[b] = 1'b1;
      rowMask[row] = mask;
      rowData[row] = $urandom();
      row++;
    end
    for (int p = 0; p < NumDouble; p++) begin
      rowMask[row] = pairMask(p);
      rowData[row] = $urandom();
      row++;
    end
    // Neighbouring rows land on different addresses
    for (int r = 0; r < NumRows; r++) begin
      rowAddr[r] = AddrWidth'((r * 7 + 3) % Depth);
      rowStatus[r] = expectedStatus(rowMask[r]);
    end
  endtask

  // One-cycle write strobe, returns on the edge that drops it
  task automatic writeWord(
    input logic [AddrWidth-1:0] addr,
    input logic [DataWidth-1:0] data,
    input logic [CodeWidth-1:0] mask
  );
    @(posedge clk);
    wrEn       <= 1'b1;
    wrAddr     <= addr;
    wrData     <= data;
    wrFlipMask <= mask;
    @(posedge clk);
    wrEn <= 1'b0;
  endtask

  // One-cycle read strobe, then waits at falling edges for rdValid
  task automatic readWord(
    input  logic [AddrWidth-1:0] addr,
    input  string                what,
    output logic [DataWidth-1:0] data,
    output eccStatusE            status,
    output logic                 valid
  );
    int waited;
    @(posedge clk);
    rdEn   <= 1'b1;
    rdAddr <= addr;
    @(posedge clk);
    rdEn <= 1'b0;
    waited = 1;
    @(negedge clk);
    while (!rdValid && waited < ValidLimit) begin
      @(negedge clk);
      waited++;
    end
    valid = rdValid;
    data = rdData;
    status = rdStatus;
    if (!valid) begin
      errorCount++;
      $display("%s: read returned no rdValid within %0d cycles", what, ValidLimit);
    end
  endtask

  initial begin
    int                    seedDummy;
    int                    errorsBefore;
    string                 name;
    logic [DataWidth-1:0]  gotData;
    eccStatusE             gotStatus;
    logic                  gotValid;
    logic                  expValid;
    logic [CountWidth-1:0] expCorr;
    logic [CountWidth-1:0] expUncorr;
    logic [AddrWidth-1:0]  expLastAddr;
    logic [DataWidth-1:0]  burstData [NumBurst];

    $timeformat(-9, 0, " ns", 0);
    seedDummy = $urandom(Seed);
    errorCount = 0;
    testCount = 0;
    testFailCount = 0;
    rst = 1'b1;
    wrEn = 1'b0;
    wrAddr = '0;
    wrData = '0;
    wrFlipMask = '0;
    rdEn = 1'b0;
    rdAddr = '0;
    buildTable();

    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;

    // The last reset edge has just cleared every register
    @(negedge clk);
    errorsBefore = errorCount;
    checkFlag(rdValid, 1'b0, "reset rdValid");
    checkCount(corrCount, '0, "reset corrCount");
    checkCount(uncorrCount, '0, "reset uncorrCount");
    checkAddr(lastErrAddr, '0, "reset lastErrAddr");
    finishTest("reset state", errorsBefore);

    // Expected log contents follow from the rows as they are applied
    expCorr = '0;
    expUncorr = '0;
    expLastAddr = '0;
    for (int r = 0; r < NumRows; r++) begin
      errorsBefore = errorCount;
      name = $sformatf("row %0d addr %0d flips %0d", r, rowAddr[r], $countones(rowMask[r]));
      writeWord(rowAddr[r], rowData[r], rowMask[r]);
      readWord(rowAddr[r], name, gotData, gotStatus, gotValid);
      if (gotValid) begin
        checkStatus(gotStatus, rowStatus[r], name);
        // Data after a double error is not trusted
        if (rowStatus[r] != EccUncorrectable) begin
          checkData(gotData, rowData[r], name);
        end
      end
      if (rowStatus[r] == EccCorrected) begin
        expCorr++;
      end else if (rowStatus[r] == EccUncorrectable) begin
        expUncorr++;
        expLastAddr = rowAddr[r];
      end
      finishTest(name, errorsBefore);
    end

    // The log takes one more edge after the final rdValid
    @(posedge clk);
    @(negedge clk);
    errorsBefore = errorCount;
    checkCount(corrCount, expCorr, "corrCount");
    checkCount(uncorrCount, expUncorr, "uncorrCount");
    checkAddr(lastErrAddr, expLastAddr, "lastErrAddr");
    finishTest("error log", errorsBefore);

    // Reads on consecutive cycles, each expected exactly two cycles after its rdEn
    errorsBefore = errorCount;
    for (int i = 0; i < NumBurst; i++) begin
      burstData[i] = $urandom();
      writeWord(AddrWidth'(i), burstData[i], '0);
    end
    for (int c = 0; c < NumBurst + 3; c++) begin
      @(posedge clk);
      if (c < NumBurst) begin
        rdEn   <= 1'b1;
        rdAddr <= AddrWidth'(c);
      end else begin
        rdEn <= 1'b0;
      end
      @(negedge clk);
      expValid = (c >= 2) && (c < NumBurst + 2);
      checkFlag(rdValid, expValid, $sformatf("burst cycle %0d rdValid", c));
      if (expValid && rdValid) begin
        checkData(rdData, burstData[c-2], $sformatf("burst word %0d", c - 2));
        checkStatus(rdStatus, EccOk, $sformatf("burst word %0d", c - 2));
      end
    end
    finishTest("back-to-back reads", errorsBefore);

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             testCount, testFailCount, errorCount);
    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
